/* bench/tb_forth_model.svh */
/* reference interpreter over the testbench code image,
   16-bit Fibonacci LFSR for random stimulus */
`ifndef TB_FORTH_MODEL_SVH
`define TB_FORTH_MODEL_SVH

// one LFSR step for each bit taken
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];  // taps 16 14 13 11
        lfsr_state = {lfsr_state[14:0], fb};
        r = {r[14:0], fb};
    end
    return r;
endfunction

// runs img from pfa until BYE or a fault and returns the host-visible results
function automatic void model_run(input logic [ASZ-1:0] pfa, output logic [DSZ-1:0] etos,
                                  output int edepth, output err_e eerr);
    logic [DSZ-1:0] st [DEPTH];
    logic [DSZ-1:0] a;
    logic [DSZ-1:0] b;
    logic [DSZ-1:0] pv;
    logic [15:0]    tgt;
    logic [ASZ-1:0] ip;
    code_byte_u     cb;
    int             sp;
    bit             do_push;
    bit             done;
    sp   = 0;
    ip   = pfa;
    eerr = ERR_NONE;
    done = 0;
    for (int steps = 0; steps < 10000 && !done; steps++) begin
        cb = img[ip];
        ip = ip + 1'b1;
        do_push = 0;
        pv = '0;
        if (cb.lit.flag) begin
            pv = DSZ'(cb.lit.val);                          // zero extended
            do_push = 1;
        end else begin
            case (cb.op.code)
            OP_NOP: ;
            OP_DOLIT: begin
                pv = {img[ip], img[ip + 1'b1], img[ip + 2'd2], img[ip + 2'd3]};
                ip = ip + 3'd4;
                do_push = 1;
            end
            OP_BRAN: begin
                tgt = {img[ip], img[ip + 1'b1]};
                ip  = tgt[ASZ-1:0];                         // absolute, truncated
            end
            OP_ZBRAN: begin
                tgt = {img[ip], img[ip + 1'b1]};
                ip  = ip + 2'd2;
                if (sp < 1) eerr = ERR_UNDER;
                else begin
                    sp = sp - 1;
                    if (st[sp] == '0) ip = tgt[ASZ-1:0];
                end
            end
            OP_BYE: done = 1;
            OP_DUP: begin
                if (sp < 1) eerr = ERR_UNDER;
                else begin
                    pv = st[sp-1];
                    do_push = 1;
                end
            end
            OP_DROP: begin
                if (sp < 1) eerr = ERR_UNDER;
                else sp = sp - 1;
            end
            OP_OVER: begin
                if (sp < 2) eerr = ERR_UNDER;
                else begin
                    pv = st[sp-2];
                    do_push = 1;
                end
            end
            OP_SWAP: begin
                if (sp < 2) eerr = ERR_UNDER;
                else begin
                    a = st[sp-1];
                    st[sp-1] = st[sp-2];
                    st[sp-2] = a;
                end
            end
            OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR: begin
                if (sp < 2) eerr = ERR_UNDER;
                else begin
                    a  = st[sp-2];                          // second cell
                    b  = st[sp-1];                          // top cell
                    sp = sp - 1;
                    case (cb.op.code)
                    OP_ADD:  st[sp-1] = a + b;
                    OP_SUB:  st[sp-1] = a - b;
                    OP_MUL:  st[sp-1] = a * b;              // low bits only
                    OP_AND:  st[sp-1] = a & b;
                    OP_OR:   st[sp-1] = a | b;
                    default: st[sp-1] = a ^ b;
                    endcase
                end
            end
            OP_NEG, OP_ABS, OP_ZEQ: begin
                if (sp < 1) eerr = ERR_UNDER;
                else if (cb.op.code == OP_NEG) st[sp-1] = -st[sp-1];
                else if (cb.op.code == OP_ABS) begin
                    if (st[sp-1][DSZ-1]) st[sp-1] = -st[sp-1];
                end else st[sp-1] = (st[sp-1] == '0) ? '1 : '0;
            end
            default: eerr = ERR_ILLEGAL;
            endcase
        end
        if (do_push && eerr == ERR_NONE) begin
            if (sp == DEPTH) eerr = ERR_OVER;               // stack left as it was
            else begin
                st[sp] = pv;
                sp = sp + 1;
            end
        end
        if (eerr != ERR_NONE) done = 1;
    end
    edepth = sp;
    etos   = (sp > 0) ? st[sp-1] : '0;
endfunction

`endif

/* bench/tb_forth_core.sv */
/* testbench for forth_core: program loading, req/ack driver,
   random and directed programs checked against the reference model */
`timescale 1ns/1ps

module tb_forth_core
    import forth_pkg::*;
;
    localparam int DSZ     = DEF_DSZ;
    localparam int ASZ     = DEF_ASZ;
    localparam int DEPTH   = DEF_DEPTH;
    localparam int DW      = $clog2(DEPTH + 1);
    localparam int TIMEOUT = 20000;          // cycles per wait

    logic           clk = 1'b0;
    logic           rst;
    logic           req;
    logic [ASZ-1:0] pfa;
    logic           ack;
    logic           prog_we;
    logic [ASZ-1:0] prog_addr;
    logic [7:0]     prog_data;
    logic [DSZ-1:0] tos;
    logic [DW-1:0]  depth;
    err_e           err;

    logic [7:0]     img [2**ASZ];           // host copy of the code memory
    logic [ASZ-1:0] wp = '0;                // next free code byte
    logic [15:0]    lfsr_state = 16'd29379;

    `include "tb_forth_model.svh"

    forth_core #(.DSZ(DSZ), .ASZ(ASZ), .DEPTH(DEPTH)) dut (
        .clk(clk), .rst(rst), .req(req), .pfa(pfa), .ack(ack),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .tos(tos), .depth(depth), .err(err)
    );

    always #10 clk = ~clk;                  // 20 ns period

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_cell(input logic [DSZ-1:0] got, input logic [DSZ-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_with_error($sformatf("mismatch at %0t: %s tos got %h expected %h",
                                      $time, what, got, exp));
    endtask

    task automatic check_depth(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                               input string what);
        if (got !== exp)
            stop_with_error($sformatf("mismatch at %0t: %s depth got %0d expected %0d",
                                      $time, what, got, exp));
    endtask

    task automatic check_err(input err_e got, input err_e exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("mismatch at %0t: %s err got %s expected %s",
                                      $time, what, got.name(), exp.name()));
    endtask

    // one byte into both the DUT memory and the model image
    task automatic emit(input logic [7:0] b);
        img[wp] = b;
        @(posedge clk);
        #2;
        prog_we   = 1'b1;
        prog_addr = wp;
        prog_data = b;
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        wp = wp + 1'b1;
    endtask

    task automatic emit_op(input opcode_e o);
        emit({1'b0, o});
    endtask

    task automatic emit_dolit(input logic [31:0] v);
        emit_op(OP_DOLIT);
        emit(v[31:24]);                     // big-endian
        emit(v[23:16]);
        emit(v[15:8]);
        emit(v[7:0]);
    endtask

    task automatic emit_rand_push();
        if (rand_bits(1)) emit({1'b1, 7'(rand_bits(7))});
        else emit_dolit({rand_bits(16), rand_bits(16)});
    endtask

    // straight-line program with depth tracked so no op faults
    task automatic random_prog(output logic [ASZ-1:0] start_pfa);
        int d;
        logic [3:0] sel;
        opcode_e o;
        start_pfa = wp;
        d = 0;
        repeat (3) begin
            emit_rand_push();
            d++;
        end
        for (int k = 0; k < 10; k++) begin
            sel = 4'(rand_bits(4));
            if (d < 2 || (sel < 4 && d < 14)) begin
                emit_rand_push();
                d++;
            end else begin
                case (sel)
                4:  o = OP_DUP;
                5:  o = OP_DROP;
                6:  o = OP_OVER;
                7:  o = OP_SWAP;
                8:  o = OP_ADD;
                9:  o = OP_SUB;
                10: o = OP_MUL;
                11: o = OP_AND;
                12: o = OP_OR;
                13: o = OP_XOR;
                14: o = OP_NEG;
                default: o = OP_ZEQ;
                endcase
                if (d >= 14) o = OP_ADD;    // keep clear of a full stack
                emit_op(o);
                if (o == OP_DUP || o == OP_OVER) d++;
                else if (o != OP_SWAP && o != OP_NEG && o != OP_ZEQ) d--;
            end
        end
        emit_op(OP_BYE);
    endtask

    // full four-phase exchange with results compared while ack is high
    task automatic run_and_check(input logic [ASZ-1:0] p, input string what);
        logic [DSZ-1:0] etos;
        int edepth;
        err_e eerr;
        int n;
        model_run(p, etos, edepth, eerr);
        @(posedge clk);
        #2;
        pfa = p;
        req = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ack && n < TIMEOUT);
        if (!ack) stop_with_error({"timeout waiting for ack to rise in ", what});
        check_err(err, eerr, what);
        check_depth(depth, DW'(edepth), what);
        if (edepth > 0) check_cell(tos, etos, what);
        repeat (2) begin                    // host stall, ack must hold
            @(posedge clk);
            #1;
            if (!ack) stop_with_error({"ack fell while req was still high in ", what});
        end
        #1;
        req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (ack && n < TIMEOUT);
        if (ack) stop_with_error({"timeout waiting for ack to fall in ", what});
    endtask

    initial begin
        logic [ASZ-1:0] p;
        logic [ASZ-1:0] p2;
        logic [ASZ-1:0] lp;
        logic [15:0]    end_a;
        rst = 1'b1;
        req = 1'b0;
        pfa = '0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) begin                    // no req, no ack
            @(posedge clk);
            #1;
            if (ack) stop_with_error("ack is high after reset without a request");
        end

        for (int i = 0; i < 6; i++) begin
            random_prog(p);
            run_and_check(p, $sformatf("random program %0d", i));
        end

        // literals above 127 and negative values
        p = wp;
        emit_dolit(32'd200);
        emit(8'hFF);                        // short literal 127
        emit_op(OP_ADD);
        emit_op(OP_NEG);
        emit_op(OP_DUP);
        emit_op(OP_ABS);
        emit_dolit(32'hFFFF_FF9C);          // -100
        emit_op(OP_ABS);
        emit_op(OP_BYE);
        run_and_check(p, "literals");

        // countdown from 5 with 0BRAN / BRAN
        p = wp;
        emit(8'h85);
        lp = wp;
        end_a = 16'(lp) + 16'd9;
        emit_op(OP_DUP);
        emit_op(OP_ZBRAN);
        emit(end_a[15:8]);
        emit(end_a[7:0]);
        emit(8'h81);
        emit_op(OP_SUB);
        emit_op(OP_BRAN);
        emit(8'(16'(lp) >> 8));
        emit(lp[7:0]);
        emit_op(OP_BYE);
        run_and_check(p, "countdown loop");

        // faults
        p = wp;
        emit_op(OP_DROP);
        emit_op(OP_BYE);
        run_and_check(p, "underflow");
        p = wp;
        for (int i = 0; i <= DEPTH; i++) emit(8'h80 | 8'(i));
        emit_op(OP_BYE);
        run_and_check(p, "overflow");
        p = wp;
        emit(8'h81);
        emit(8'h7F);
        run_and_check(p, "illegal opcode");

        // two words back to back on a freshly cleared stack each
        random_prog(p);
        random_prog(p2);
        run_and_check(p, "first of two runs");
        run_and_check(p2, "second of two runs");

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #5ms;
        stop_with_error("simulation time limit reached");
    end

endmodule

/* hw/code_mem.sv */
/* byte-wide code memory
   host write port, registered fetch port */
`timescale 1ns/1ps

module code_mem
    import forth_pkg::*;
#(
    parameter int ASZ = DEF_ASZ
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           prog_we,
    input  logic [ASZ-1:0] prog_addr,
    input  logic [7:0]     prog_data,
    input  logic [ASZ-1:0] fetch_addr,
    output logic [7:0]     fetch_data
);
    logic [7:0] mem [2**ASZ];           // bytecode store

    always_ff @(posedge clk) begin
        if (prog_we) mem[prog_addr] <= prog_data;   // host loads program
    end

    // one cycle fetch latency
    always_ff @(posedge clk) begin
        if (rst) fetch_data <= '0;
        else fetch_data <= mem[fetch_addr];
    end

    // interp parks fetch_addr at the top byte while idle,
    // host writes go below it, so reads never see a write in flight
    a_no_rw_clash: assert property (@(posedge clk) disable iff (rst)
        prog_we |-> prog_addr != fetch_addr);

endmodule

/* hw/data_stack.sv */
/* data stack with tos / nos held in registers,
   deeper cells spilled to an array, combinational fault check */
`timescale 1ns/1ps

module data_stack
    import forth_pkg::*;
#(
    parameter int DSZ   = DEF_DSZ,
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       op_valid,
    input  sop_e                       sop,
    input  logic [DSZ-1:0]             push_val,
    output logic [DSZ-1:0]             tos,
    output logic [DSZ-1:0]             nos,
    output logic [$clog2(DEPTH+1)-1:0] depth,
    output err_e                       fault
);
    localparam int DW = $clog2(DEPTH + 1);  // depth counter width
    localparam int IW = $clog2(DEPTH - 2);  // spill index width

    logic [DSZ-1:0] spill [DEPTH-2];        // cells below nos
    logic [DW-1:0]  sp;                     // spill pointer, next free slot
    logic           ok;                     // request accepted

    assign sp = depth - DW'(2);             // only meaningful for depth >= 2
    assign ok = op_valid && fault == ERR_NONE;

    // check the request against the cells held
    always_comb begin
        fault = ERR_NONE;
        if (op_valid) begin
            case (sop)
            SS_LOAD: if (depth == '0) fault = ERR_UNDER;
            SS_PUSH: if (depth == DW'(DEPTH)) fault = ERR_OVER;
            SS_POP:  if (depth == '0) fault = ERR_UNDER;
            SS_ALU:  if (depth < DW'(2)) fault = ERR_UNDER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) depth <= '0;
        else if (ok) begin
            case (sop)
            SS_PUSH:        depth <= depth + 1'b1;
            SS_POP, SS_ALU: depth <= depth - 1'b1;
            default:        ;                   // load keeps depth
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            tos <= '0;                          // defined results on empty stack
            nos <= '0;
        end else if (ok) begin
            case (sop)
            SS_LOAD: tos <= push_val;
            SS_PUSH: begin
                tos <= push_val;
                nos <= tos;
                if (depth >= DW'(2)) spill[IW'(sp)] <= nos;     // nos moves down
            end
            SS_POP: begin
                tos <= nos;
                if (depth >= DW'(3)) nos <= spill[IW'(sp - 1'b1)];
            end
            SS_ALU: begin
                tos <= push_val;                // result from s0 op tos
                if (depth >= DW'(3)) nos <= spill[IW'(sp - 1'b1)];
            end
            endcase
        end
    end

    a_depth_max: assert property (@(posedge clk) disable iff (rst)
        depth <= DW'(DEPTH));

endmodule

/* hw/forth_core.sv */
/* forth core top: code memory, data stack,
   inner interpreter and run controller */
`timescale 1ns/1ps

module forth_core
    import forth_pkg::*;
#(
    parameter int DSZ   = DEF_DSZ,
    parameter int ASZ   = DEF_ASZ,
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  logic [ASZ-1:0]             pfa,
    output logic                       ack,
    input  logic                       prog_we,
    input  logic [ASZ-1:0]             prog_addr,
    input  logic [7:0]                 prog_data,
    output logic [DSZ-1:0]             tos,
    output logic [$clog2(DEPTH+1)-1:0] depth,
    output err_e                       err
);
    logic           start;
    logic [ASZ-1:0] entry_pfa;
    logic           halt;
    err_e           cause;
    logic [ASZ-1:0] fetch_addr;
    logic [7:0]     fetch_data;
    logic           op_valid;
    sop_e           sop;
    logic [DSZ-1:0] push_val;
    logic [DSZ-1:0] nos;
    err_e           fault;

    code_mem #(.ASZ(ASZ)) u_mem (
        .clk(clk), .rst(rst),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data)
    );

    data_stack #(.DSZ(DSZ), .DEPTH(DEPTH)) u_stack (
        .clk(clk), .rst(rst), .clear(start),  // each run starts empty
        .op_valid(op_valid), .sop(sop), .push_val(push_val),
        .tos(tos), .nos(nos), .depth(depth), .fault(fault)
    );

    inner_interp #(.DSZ(DSZ), .ASZ(ASZ)) u_interp (
        .clk(clk), .rst(rst), .start(start), .entry_pfa(entry_pfa),
        .busy(), .halt(halt), .cause(cause),    // busy only used inside
        .fetch_addr(fetch_addr), .fetch_data(fetch_data),
        .op_valid(op_valid), .sop(sop), .push_val(push_val),
        .tos(tos), .nos(nos), .fault(fault)
    );

    run_ctrl #(.ASZ(ASZ)) u_ctrl (
        .clk(clk), .rst(rst), .req(req), .pfa(pfa), .ack(ack),
        .start(start), .entry_pfa(entry_pfa),
        .halt(halt), .cause(cause), .err(err)
    );

endmodule

/* hw/forth_pkg.sv */
/* shared definitions for the forth core: default widths,
   opcode / stack-op / halt-cause enums, code byte union */
package forth_pkg;

    localparam int DEF_DSZ   = 32;      // cell width
    localparam int DEF_ASZ   = 12;      // code address width, 4K bytes
    localparam int DEF_DEPTH = 16;      // data stack cells

    // executed opcode subset, numbering is fixed
    typedef enum logic [6:0] {
        OP_NOP   = 7'd0,
        OP_DOLIT,                       // 4 literal bytes follow, big-endian
        OP_BRAN,                        // 2 target bytes follow
        OP_ZBRAN,                       // pop flag, branch if zero
        OP_BYE,                         // normal halt
        OP_DUP,
        OP_DROP,
        OP_OVER,
        OP_SWAP,
        OP_ADD,
        OP_SUB,
        OP_MUL,                         // low DSZ bits kept
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NEG,
        OP_ABS,
        OP_ZEQ                          // -1 if tos is zero, else 0
    } opcode_e;

    // one code byte, two readings picked by bit 7
    typedef union packed {
        struct packed {
            logic    flag;              // 0 for an opcode
            opcode_e code;
        } op;
        struct packed {
            logic       flag;           // 1 for a short literal
            logic [6:0] val;            // pushed zero-extended
        } lit;
    } code_byte_u;

    // data stack request
    typedef enum logic [1:0] {
        SS_LOAD,                        // replace top
        SS_PUSH,
        SS_POP,
        SS_ALU                          // pop, then replace top
    } sop_e;

    // halt cause seen by the host
    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_UNDER,                      // pop or read below bottom
        ERR_OVER,                       // push onto a full stack
        ERR_ILLEGAL                     // unknown opcode
    } err_e;

endpackage

/* hw/inner_interp.sv */
/* inner interpreter FSM: fetch, execute, operand bytes
   decodes code bytes and drives the data stack */
`timescale 1ns/1ps

module inner_interp
    import forth_pkg::*;
#(
    parameter int DSZ = DEF_DSZ,
    parameter int ASZ = DEF_ASZ
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic [ASZ-1:0] entry_pfa,
    output logic           busy,
    output logic           halt,
    output err_e           cause,
    output logic [ASZ-1:0] fetch_addr,
    input  logic [7:0]     fetch_data,
    output logic           op_valid,
    output sop_e           sop,
    output logic [DSZ-1:0] push_val,
    input  logic [DSZ-1:0] tos,
    input  logic [DSZ-1:0] nos,
    input  err_e           fault
);
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;  // opcode address out
    localparam logic [1:0] S_EXEC  = 2'd2;  // opcode byte back, run it
    localparam logic [1:0] S_OPND  = 2'd3;  // operand bytes, swap second half

    logic [1:0]     state;
    logic [ASZ-1:0] ip;                     // instruction pointer
    opcode_e        op_r;                   // opcode waiting for operands
    logic [2:0]     cnt;                    // operand cycles left
    logic [2:0]     xtra;                   // extra cycles of this opcode
    logic [DSZ-1:0] oper;                   // operand shift reg / saved nos
    logic [DSZ-1:0] opnd;                   // operand with current byte
    code_byte_u     cb;

    assign busy       = state != S_IDLE;
    assign fetch_addr = busy ? ip : '1;     // parked at the top byte when idle

    task stk(input sop_e s, input logic [DSZ-1:0] v);
        op_valid = 1'b1;
        sop      = s;
        push_val = v;
    endtask

    always_comb begin
        cb       = fetch_data;
        opnd     = {oper[DSZ-9:0], fetch_data};   // big-endian shift
        op_valid = 1'b0;
        sop      = SS_LOAD;
        push_val = tos;
        xtra     = '0;
        halt     = 1'b0;
        cause    = ERR_NONE;
        if (state == S_EXEC) begin
            if (cb.lit.flag) stk(SS_PUSH, DSZ'(cb.lit.val));  // short literal
            else begin
                case (cb.op.code)
                OP_NOP:            ;
                OP_DOLIT:          xtra = 3'd4;
                OP_BRAN, OP_ZBRAN: xtra = 3'd2;
                OP_BYE:            halt = 1'b1;
                OP_DUP:            stk(SS_PUSH, tos);
                OP_DROP:           stk(SS_POP, tos);
                OP_OVER:           stk(SS_PUSH, nos);
                OP_SWAP: begin
                    stk(SS_ALU, tos);       // drop nos, push it back next cycle
                    xtra = 3'd1;
                end
                OP_ADD:            stk(SS_ALU, nos + tos);
                OP_SUB:            stk(SS_ALU, nos - tos);
                OP_MUL:            stk(SS_ALU, nos * tos);
                OP_AND:            stk(SS_ALU, nos & tos);
                OP_OR:             stk(SS_ALU, nos | tos);
                OP_XOR:            stk(SS_ALU, nos ^ tos);
                OP_NEG:            stk(SS_LOAD, -tos);
                OP_ABS:            stk(SS_LOAD, tos[DSZ-1] ? -tos : tos);
                OP_ZEQ:            stk(SS_LOAD, {DSZ{tos == '0}});
                default: begin
                    halt  = 1'b1;
                    cause = ERR_ILLEGAL;
                end
                endcase
            end
        end else if (state == S_OPND && cnt == 3'd1) begin
            case (op_r)                     // last operand byte is on fetch_data
            OP_DOLIT: stk(SS_PUSH, opnd);
            OP_ZBRAN: stk(SS_POP, tos);     // flag is the old tos
            OP_SWAP:  stk(SS_PUSH, oper);
            default:  ;                     // BRAN moves ip only
            endcase
        end
        if (op_valid && fault != ERR_NONE) begin
            halt  = 1'b1;                   // stack left untouched
            cause = fault;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) state <= S_IDLE;
        else begin
            case (state)
            S_IDLE:  if (start) state <= S_FETCH;
            S_FETCH: state <= S_EXEC;
            S_EXEC:  state <= halt ? S_IDLE : (xtra != '0 ? S_OPND : S_FETCH);
            S_OPND:  if (cnt == 3'd1) state <= halt ? S_IDLE : S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
        S_IDLE:  if (start) ip <= entry_pfa;
        S_FETCH: ip <= ip + 1'b1;
        S_EXEC: begin
            op_r <= cb.op.code;
            cnt  <= xtra;
            oper <= nos;
            if (xtra > 3'd1) ip <= ip + 1'b1;   // first operand byte requested
        end
        S_OPND: begin
            oper <= opnd;
            cnt  <= cnt - 1'b1;
            if (cnt != 3'd1) ip <= ip + 1'b1;
            else if (op_r == OP_BRAN || (op_r == OP_ZBRAN && tos == '0))
                ip <= opnd[ASZ-1:0];            // absolute target, truncated
        end
        endcase
    end

    // halt ends the run right away
    a_halt_busy: assert property (@(posedge clk) disable iff (rst)
        halt |-> busy ##1 !busy);

endmodule

/* hw/run_ctrl.sv */
/* run controller: four-phase req/ack with the host,
   entry pfa register, halt cause register */
`timescale 1ns/1ps

module run_ctrl
    import forth_pkg::*;
#(
    parameter int ASZ = DEF_ASZ
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           req,
    input  logic [ASZ-1:0] pfa,
    output logic           ack,
    output logic           start,
    output logic [ASZ-1:0] entry_pfa,
    input  logic           halt,
    input  err_e           cause,
    output err_e           err
);
    logic req_q;                            // req one cycle ago
    logic running;                          // started, no halt seen yet
    logic launch;

    assign launch = req && !req_q && !running && !ack;  // rising req while idle

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q   <= 1'b0;
            running <= 1'b0;
            start   <= 1'b0;
            ack     <= 1'b0;
            err     <= ERR_NONE;
        end else begin
            req_q <= req;
            start <= launch;                // one cycle pulse
            if (launch) running <= 1'b1;
            if (running && halt) begin
                running <= 1'b0;
                ack     <= 1'b1;            // results valid from here
                err     <= cause;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) entry_pfa <= pfa;       // host holds pfa with req
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req);

endmodule

/* project.f */
+incdir+bench
hw/forth_pkg.sv
hw/code_mem.sv
hw/data_stack.sv
hw/inner_interp.sv
hw/run_ctrl.sv
hw/forth_core.sv
bench/tb_forth_core.sv

/* run.sh */
#!/bin/sh
# build and run the forth core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_forth_core -f project.f \
    --Mdir obj_dir -o sim_forth
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_forth
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
